//--- rv_pkg.sv
package rv_pkg;

    // ------------------------------------------------------------------------
    // Widths and predictor geometry
    // ------------------------------------------------------------------------
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int BP_ENTRIES = 64;
    localparam int BP_IDX_W   = 6;

    localparam logic [XLEN-1:0] RESET_PC = '0;

    // Major opcodes of the kept instruction set
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // 2-bit saturating counter, upper bit means predict taken
    typedef enum logic [1:0] {
        BHT_SNT = 2'b00,
        BHT_WNT = 2'b01,
        BHT_WT  = 2'b10,
        BHT_ST  = 2'b11
    } bht_state_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_B
    } alu_op_e;

    typedef struct packed {
        logic    reg_write;
        logic    use_imm;
        logic    is_branch;
        logic    is_jal;
        alu_op_e alu_op;
    } dec_ctrl_t;

endpackage

//--- rv_pipe_if.sv
// Fetch to decode
interface fd_if;
    logic                    valid;
    logic [rv_pkg::XLEN-1:0] pc;
    logic [rv_pkg::XLEN-1:0] instr;
    logic                    pred_taken;
    logic [rv_pkg::XLEN-1:0] pred_target;

    modport producer (output valid, pc, instr, pred_taken, pred_target);
    modport consumer (input  valid, pc, instr, pred_taken, pred_target);
endinterface

// Decode to execute
interface dx_if;
    logic                          valid;
    logic [rv_pkg::XLEN-1:0]       pc;
    logic [rv_pkg::REG_ADDR_W-1:0] rs1;
    logic [rv_pkg::REG_ADDR_W-1:0] rs2;
    logic [rv_pkg::REG_ADDR_W-1:0] rd;
    logic [2:0]                    funct3;
    logic [rv_pkg::XLEN-1:0]       imm;
    logic [rv_pkg::XLEN-1:0]       rs1_data;
    logic [rv_pkg::XLEN-1:0]       rs2_data;
    rv_pkg::dec_ctrl_t             ctrl;
    logic                          pred_taken;
    logic [rv_pkg::XLEN-1:0]       pred_target;

    modport producer (output valid, pc, rs1, rs2, rd, funct3, imm, rs1_data, rs2_data,
                             ctrl, pred_taken, pred_target);
    modport consumer (input  valid, pc, rs1, rs2, rd, funct3, imm, rs1_data, rs2_data,
                             ctrl, pred_taken, pred_target);
endinterface

// Execute to writeback
interface xw_if;
    logic                          valid;
    logic [rv_pkg::XLEN-1:0]       pc;
    logic [rv_pkg::REG_ADDR_W-1:0] rd;
    logic                          reg_write;
    logic [rv_pkg::XLEN-1:0]       result;

    modport producer (output valid, pc, rd, reg_write, result);
    modport consumer (input  valid, pc, rd, reg_write, result);
endinterface

// Execute back to fetch, redirect plus predictor training
interface redirect_if;
    logic                    redirect;
    logic [rv_pkg::XLEN-1:0] redirect_pc;
    logic                    upd_valid;
    logic [rv_pkg::XLEN-1:0] upd_pc;
    logic                    upd_taken;
    logic [rv_pkg::XLEN-1:0] upd_target;
    logic                    upd_jal;

    modport producer (output redirect, redirect_pc, upd_valid, upd_pc, upd_taken,
                             upd_target, upd_jal);
    modport consumer (input  redirect, redirect_pc, upd_valid, upd_pc, upd_taken,
                             upd_target, upd_jal);
endinterface

//--- branch_predictor.sv
module branch_predictor (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [rv_pkg::XLEN-1:0] lookup_pc_i,
    output logic                    pred_taken_o,
    output logic [rv_pkg::XLEN-1:0] pred_target_o,
    input  logic                    upd_valid_i,
    input  logic [rv_pkg::XLEN-1:0] upd_pc_i,
    input  logic                    upd_taken_i,
    input  logic [rv_pkg::XLEN-1:0] upd_target_i,
    input  logic                    upd_jal_i
);
    rv_pkg::bht_state_e      bht_q [rv_pkg::BP_ENTRIES];
    logic [rv_pkg::XLEN-1:0] btb_q [rv_pkg::BP_ENTRIES];

    logic [rv_pkg::BP_IDX_W-1:0] lk_idx;
    logic [rv_pkg::BP_IDX_W-1:0] up_idx;
    logic [1:0]                  lk_state;

    // Word-aligned PC bits select the entry
    assign lk_idx = lookup_pc_i[rv_pkg::BP_IDX_W+1:2];
    assign up_idx = upd_pc_i[rv_pkg::BP_IDX_W+1:2];

    assign lk_state      = bht_q[lk_idx];
    assign pred_taken_o  = lk_state[1];
    assign pred_target_o = btb_q[lk_idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < rv_pkg::BP_ENTRIES; i++) begin
                bht_q[i] <= rv_pkg::BHT_WNT;
                btb_q[i] <= '0;
            end
        end else if (upd_valid_i) begin
            btb_q[up_idx] <= upd_target_i;
            if (upd_jal_i) begin
                bht_q[up_idx] <= rv_pkg::BHT_ST;
            end else if (upd_taken_i && bht_q[up_idx] != rv_pkg::BHT_ST) begin
                bht_q[up_idx] <= rv_pkg::bht_state_e'(bht_q[up_idx] + 2'd1);
            end else if (!upd_taken_i && bht_q[up_idx] != rv_pkg::BHT_SNT) begin
                bht_q[up_idx] <= rv_pkg::bht_state_e'(bht_q[up_idx] - 2'd1);
            end
        end
    end

endmodule

//--- fetch_stage.sv
module fetch_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    output logic [rv_pkg::XLEN-1:0] imem_addr_o,
    input  logic [rv_pkg::XLEN-1:0] imem_data_i,
    fd_if.producer                  fd,
    redirect_if.consumer            redir
);
    logic [rv_pkg::XLEN-1:0] pc_q;
    logic [rv_pkg::XLEN-1:0] pc_next;
    logic [rv_pkg::XLEN-1:0] pred_target;
    logic                    pred_taken;

    branch_predictor u_bp (
        .clk          (clk),
        .rst_n        (rst_n),
        .lookup_pc_i  (pc_q),
        .pred_taken_o (pred_taken),
        .pred_target_o(pred_target),
        .upd_valid_i  (redir.upd_valid),
        .upd_pc_i     (redir.upd_pc),
        .upd_taken_i  (redir.upd_taken),
        .upd_target_i (redir.upd_target),
        .upd_jal_i    (redir.upd_jal)
    );

    assign imem_addr_o = pc_q;

    // Redirect from execute wins over the prediction
    always_comb begin
        if (redir.redirect) begin
            pc_next = redir.redirect_pc;
        end else if (pred_taken) begin
            pc_next = pred_target;
        end else begin
            pc_next = pc_q + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q     <= rv_pkg::RESET_PC;
            fd.valid <= 1'b0;
        end else begin
            pc_q     <= pc_next;
            fd.valid <= !redir.redirect;
        end
    end

    always_ff @(posedge clk) begin
        fd.pc          <= pc_q;
        fd.instr       <= imem_data_i;
        fd.pred_taken  <= pred_taken;
        fd.pred_target <= pred_target;
    end

endmodule

//--- regfile.sv
module regfile (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs1_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs2_i,
    output logic [rv_pkg::XLEN-1:0]       rs1_data_o,
    output logic [rv_pkg::XLEN-1:0]       rs2_data_o,
    input  logic                          we_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rd_i,
    input  logic [rv_pkg::XLEN-1:0]       wdata_i
);
    logic [rv_pkg::XLEN-1:0] regs_q [32];

    assign rs1_data_o = regs_q[rs1_i];
    assign rs2_data_o = regs_q[rs2_i];

    // x0 is never written, so it reads zero from reset on
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin
            regs_q[rd_i] <= wdata_i;
        end
    end

endmodule

//--- decode_stage.sv
module decode_stage (
    input  logic   clk,
    input  logic   rst_n,
    fd_if.consumer fd,
    dx_if.producer dx,
    xw_if.consumer wb,
    input  logic   flush_i
);
    logic [6:0]                    opcode;
    logic [2:0]                    funct3;
    logic [rv_pkg::REG_ADDR_W-1:0] rs1;
    logic [rv_pkg::REG_ADDR_W-1:0] rs2;
    logic [rv_pkg::REG_ADDR_W-1:0] rd;
    logic [rv_pkg::XLEN-1:0]       imm;
    logic [rv_pkg::XLEN-1:0]       rf_rs1;
    logic [rv_pkg::XLEN-1:0]       rf_rs2;
    logic                          wb_wr;
    logic                          alt;
    rv_pkg::dec_ctrl_t             ctrl;

    function automatic rv_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic sub_sra);
        rv_pkg::alu_op_e op;
        case (f3)
            3'b000:  op = sub_sra ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  op = rv_pkg::ALU_SLL;
            3'b010:  op = rv_pkg::ALU_SLT;
            3'b011:  op = rv_pkg::ALU_SLTU;
            3'b100:  op = rv_pkg::ALU_XOR;
            3'b101:  op = sub_sra ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  op = rv_pkg::ALU_OR;
            default: op = rv_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode = fd.instr[6:0];
    assign rd     = fd.instr[11:7];
    assign funct3 = fd.instr[14:12];
    assign rs1    = fd.instr[19:15];
    assign rs2    = fd.instr[24:20];

    // ADDI has no subtract form, only the immediate shifts honour bit 30
    assign alt = fd.instr[30] && (opcode == rv_pkg::OPC_OP || funct3 == 3'b101);

    always_comb begin
        case (opcode)
            rv_pkg::OPC_OP_IMM: imm = {{20{fd.instr[31]}}, fd.instr[31:20]};
            rv_pkg::OPC_BRANCH: imm = {{19{fd.instr[31]}}, fd.instr[31], fd.instr[7],
                                       fd.instr[30:25], fd.instr[11:8], 1'b0};
            rv_pkg::OPC_LUI:    imm = {fd.instr[31:12], 12'b0};
            rv_pkg::OPC_JAL:    imm = {{11{fd.instr[31]}}, fd.instr[31], fd.instr[19:12],
                                       fd.instr[20], fd.instr[30:21], 1'b0};
            default:            imm = '0;
        endcase
    end

    // Unknown opcodes fall out as a no-op
    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = alu_sel(funct3, alt);
        case (opcode)
            rv_pkg::OPC_OP: begin
                ctrl.reg_write = 1'b1;
            end
            rv_pkg::OPC_OP_IMM: begin
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
            end
            rv_pkg::OPC_LUI: begin
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.alu_op    = rv_pkg::ALU_PASS_B;
            end
            rv_pkg::OPC_JAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.is_jal    = 1'b1;
            end
            rv_pkg::OPC_BRANCH: begin
                ctrl.is_branch = 1'b1;
            end
            default: begin
                ctrl.alu_op = rv_pkg::ALU_ADD;
            end
        endcase
    end

    regfile u_regfile (
        .clk       (clk),
        .rst_n     (rst_n),
        .rs1_i     (rs1),
        .rs2_i     (rs2),
        .rs1_data_o(rf_rs1),
        .rs2_data_o(rf_rs2),
        .we_i      (wb.valid && wb.reg_write),
        .rd_i      (wb.rd),
        .wdata_i   (wb.result)
    );

    // Writeback bypass covers the write landing on this same edge
    assign wb_wr = wb.valid && wb.reg_write && (wb.rd != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dx.valid <= 1'b0;
        end else begin
            dx.valid <= fd.valid && !flush_i;
        end
    end

    always_ff @(posedge clk) begin
        dx.pc          <= fd.pc;
        dx.rs1         <= rs1;
        dx.rs2         <= rs2;
        dx.rd          <= ctrl.reg_write ? rd : '0;
        dx.funct3      <= funct3;
        dx.imm         <= imm;
        dx.rs1_data    <= (wb_wr && wb.rd == rs1) ? wb.result : rf_rs1;
        dx.rs2_data    <= (wb_wr && wb.rd == rs2) ? wb.result : rf_rs2;
        dx.ctrl        <= ctrl;
        dx.pred_taken  <= fd.pred_taken;
        dx.pred_target <= fd.pred_target;
    end

endmodule

//--- alu.sv
module alu (
    input  logic [rv_pkg::XLEN-1:0] a_i,
    input  logic [rv_pkg::XLEN-1:0] b_i,
    input  rv_pkg::alu_op_e         op_i,
    output logic [rv_pkg::XLEN-1:0] y_o
);
    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b_i[4:0];
    assign lt_s  = $signed(a_i) < $signed(b_i);
    assign lt_u  = a_i < b_i;

    always_comb begin
        case (op_i)
            rv_pkg::ALU_ADD:  y_o = a_i + b_i;
            rv_pkg::ALU_SUB:  y_o = a_i - b_i;
            rv_pkg::ALU_AND:  y_o = a_i & b_i;
            rv_pkg::ALU_OR:   y_o = a_i | b_i;
            rv_pkg::ALU_XOR:  y_o = a_i ^ b_i;
            rv_pkg::ALU_SLL:  y_o = a_i << shamt;
            rv_pkg::ALU_SRL:  y_o = a_i >> shamt;
            rv_pkg::ALU_SRA:  y_o = $signed(a_i) >>> shamt;
            rv_pkg::ALU_SLT:  y_o = {{(rv_pkg::XLEN-1){1'b0}}, lt_s};
            rv_pkg::ALU_SLTU: y_o = {{(rv_pkg::XLEN-1){1'b0}}, lt_u};
            default:          y_o = b_i;
        endcase
    end

endmodule

//--- execute_stage.sv
module execute_stage (
    input  logic        clk,
    input  logic        rst_n,
    dx_if.consumer      dx,
    xw_if.producer      xw,
    redirect_if.producer redir
);
    logic [rv_pkg::XLEN-1:0] op_a;
    logic [rv_pkg::XLEN-1:0] op_b;
    logic [rv_pkg::XLEN-1:0] alu_b;
    logic [rv_pkg::XLEN-1:0] alu_y;
    logic [rv_pkg::XLEN-1:0] pc_plus4;
    logic [rv_pkg::XLEN-1:0] target;
    logic [rv_pkg::XLEN-1:0] actual_next;
    logic [rv_pkg::XLEN-1:0] pred_next;
    logic [rv_pkg::XLEN-1:0] result;
    logic                    xw_wr;
    logic                    cond;
    logic                    taken;

    // ------------------------------------------------------------------------
    // Operand forwarding from the execute/writeback register
    // ------------------------------------------------------------------------
    assign xw_wr = xw.valid && xw.reg_write && (xw.rd != '0);
    assign op_a  = (xw_wr && xw.rd == dx.rs1) ? xw.result : dx.rs1_data;
    assign op_b  = (xw_wr && xw.rd == dx.rs2) ? xw.result : dx.rs2_data;
    assign alu_b = dx.ctrl.use_imm ? dx.imm : op_b;

    alu u_alu (
        .a_i (op_a),
        .b_i (alu_b),
        .op_i(dx.ctrl.alu_op),
        .y_o (alu_y)
    );

    // ------------------------------------------------------------------------
    // Branch and jump resolution
    // ------------------------------------------------------------------------
    always_comb begin
        case (dx.funct3)
            3'b000:  cond = op_a == op_b;
            3'b001:  cond = op_a != op_b;
            3'b100:  cond = $signed(op_a) < $signed(op_b);
            3'b101:  cond = $signed(op_a) >= $signed(op_b);
            3'b110:  cond = op_a < op_b;
            3'b111:  cond = op_a >= op_b;
            default: cond = 1'b0;
        endcase
    end

    // Decode already picked the B or J immediate
    assign pc_plus4    = dx.pc + 32'd4;
    assign target      = dx.pc + dx.imm;
    assign taken       = dx.ctrl.is_jal || (dx.ctrl.is_branch && cond);
    assign actual_next = taken ? target : pc_plus4;
    assign pred_next   = dx.pred_taken ? dx.pred_target : pc_plus4;

    assign redir.redirect    = dx.valid && (actual_next != pred_next);
    assign redir.redirect_pc = actual_next;
    assign redir.upd_valid   = dx.valid && (dx.ctrl.is_branch || dx.ctrl.is_jal);
    assign redir.upd_pc      = dx.pc;
    assign redir.upd_taken   = taken;
    assign redir.upd_target  = target;
    assign redir.upd_jal     = dx.ctrl.is_jal;

    // Anything retiring to x0 carries zero
    always_comb begin
        if (dx.rd == '0) begin
            result = '0;
        end else if (dx.ctrl.is_jal) begin
            result = pc_plus4;
        end else begin
            result = alu_y;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            xw.valid <= 1'b0;
        end else begin
            xw.valid <= dx.valid;
        end
    end

    always_ff @(posedge clk) begin
        xw.pc        <= dx.pc;
        xw.rd        <= dx.rd;
        xw.reg_write <= dx.ctrl.reg_write;
        xw.result    <= result;
    end

endmodule

//--- rv_core.sv
module rv_core (
    input  logic                          clk,
    input  logic                          rst_n,
    output logic [rv_pkg::XLEN-1:0]       imem_addr_o,
    input  logic [rv_pkg::XLEN-1:0]       imem_data_i,
    output logic                          retire_valid_o,
    output logic [rv_pkg::XLEN-1:0]       retire_pc_o,
    output logic [rv_pkg::REG_ADDR_W-1:0] retire_rd_o,
    output logic [rv_pkg::XLEN-1:0]       retire_data_o,
    output logic                          redirect_o
);
    fd_if       fd_bus ();
    dx_if       dx_bus ();
    xw_if       xw_bus ();
    redirect_if redir_bus ();

    fetch_stage u_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr_o(imem_addr_o),
        .imem_data_i(imem_data_i),
        .fd         (fd_bus),
        .redir      (redir_bus)
    );

    // A misprediction squashes the instruction in decode as well
    decode_stage u_decode (
        .clk    (clk),
        .rst_n  (rst_n),
        .fd     (fd_bus),
        .dx     (dx_bus),
        .wb     (xw_bus),
        .flush_i(redir_bus.redirect)
    );

    execute_stage u_execute (
        .clk  (clk),
        .rst_n(rst_n),
        .dx   (dx_bus),
        .xw   (xw_bus),
        .redir(redir_bus)
    );

    // Retirement is the writeback cycle
    assign retire_valid_o = xw_bus.valid;
    assign retire_pc_o    = xw_bus.pc;
    assign retire_rd_o    = xw_bus.rd;
    assign retire_data_o  = xw_bus.result;
    assign redirect_o     = redir_bus.redirect;

endmodule

//--- rv_checker.sv
module rv_checker (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          retire_valid_i,
    input  logic [rv_pkg::XLEN-1:0]       retire_pc_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] retire_rd_i,
    input  logic [rv_pkg::XLEN-1:0]       retire_data_i,
    input  logic                          redirect_i,
    output int                            retired_o,
    output int                            expected_o,
    output int                            errors_o,
    output logic                          done_o
);
    logic [rv_pkg::XLEN-1:0]       exp_pc [$];
    logic [rv_pkg::REG_ADDR_W-1:0] exp_rd [$];
    logic [rv_pkg::XLEN-1:0]       exp_data [$];
    int                            exp_redirects;
    int                            redirects;

    // Reads the R and C lines; P lines belong to the memory model
    task automatic read_expected();
        int                            fd;
        int                            code;
        logic [7:0]                    tag;
        logic [rv_pkg::XLEN-1:0]       a;
        logic [rv_pkg::REG_ADDR_W-1:0] b;
        logic [rv_pkg::XLEN-1:0]       c;
        logic [8*160-1:0]              rest;
        fd = $fopen("rv_core_golden.txt", "r");
        if (fd == 0) begin
            $display("checker could not open the golden file");
            errors_o++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", tag);
            if (code != 1) begin
                break;
            end
            case (tag)
                "R": begin
                    code = $fscanf(fd, "%h %h %h", a, b, c);
                    exp_pc.push_back(a);
                    exp_rd.push_back(b);
                    exp_data.push_back(c);
                end
                "C": code = $fscanf(fd, "%d", exp_redirects);
                default: code = $fgets(rest, fd);
            endcase
        end
        $fclose(fd);
        expected_o = exp_pc.size();
    endtask

    initial begin
        retired_o     = 0;
        expected_o    = 0;
        errors_o      = 0;
        done_o        = 1'b0;
        redirects     = 0;
        exp_redirects = -1;
        read_expected();
    end

    // ------------------------------------------------------------------------
    // Sampled mid-cycle, away from both the edge and input changes
    // ------------------------------------------------------------------------
    always @(negedge clk) begin
        if (!rst_n) begin
            if (retire_valid_i !== 1'b0 || redirect_i !== 1'b0) begin
                $display("CHECK FAILED at %0t: retire or redirect not low in reset", $time);
                errors_o++;
            end
        end else if (!done_o && expected_o > 0) begin
            if (redirect_i === 1'b1) begin
                redirects++;
            end
            if (retire_valid_i !== 1'b0) begin
                if (retire_pc_i !== exp_pc[retired_o] ||
                    retire_rd_i !== exp_rd[retired_o] ||
                    retire_data_i !== exp_data[retired_o]) begin
                    $display("CHECK FAILED at %0t: retire %0d got %h/%0d/%h, expected %h/%0d/%h",
                             $time, retired_o, retire_pc_i, retire_rd_i, retire_data_i,
                             exp_pc[retired_o], exp_rd[retired_o], exp_data[retired_o]);
                    errors_o++;
                end
                retired_o++;
                if (retired_o == expected_o) begin
                    done_o = 1'b1;
                    if (redirects != exp_redirects) begin
                        $display("CHECK FAILED at %0t: %0d redirects, expected %0d",
                                 $time, redirects, exp_redirects);
                        errors_o++;
                    end
                end
            end
        end
    end

endmodule

//--- tb_rv_core.sv
module tb_rv_core;

    localparam int RETIRE_TIMEOUT = 100;

    logic                          clk;
    logic                          rst_n;
    logic [rv_pkg::XLEN-1:0]       imem_addr;
    logic [rv_pkg::XLEN-1:0]       imem_data;
    logic                          retire_valid;
    logic [rv_pkg::XLEN-1:0]       retire_pc;
    logic [rv_pkg::REG_ADDR_W-1:0] retire_rd;
    logic [rv_pkg::XLEN-1:0]       retire_data;
    logic                          redirect;
    int                            retired;
    int                            expected;
    int                            chk_errors;
    logic                          done;
    logic [rv_pkg::XLEN-1:0]       imem [64];
    int                            tb_errors;
    int                            prog_words;
    int                            seen;
    int                            waited;

    always #20 clk = ~clk;

    // Instruction memory answers in the same cycle
    assign imem_data = imem[imem_addr[7:2]];

    rv_core u_rv_core (
        .clk           (clk),
        .rst_n         (rst_n),
        .imem_addr_o   (imem_addr),
        .imem_data_i   (imem_data),
        .retire_valid_o(retire_valid),
        .retire_pc_o   (retire_pc),
        .retire_rd_o   (retire_rd),
        .retire_data_o (retire_data),
        .redirect_o    (redirect)
    );

    rv_checker u_checker (
        .clk           (clk),
        .rst_n         (rst_n),
        .retire_valid_i(retire_valid),
        .retire_pc_i   (retire_pc),
        .retire_rd_i   (retire_rd),
        .retire_data_i (retire_data),
        .redirect_i    (redirect),
        .retired_o     (retired),
        .expected_o    (expected),
        .errors_o      (chk_errors),
        .done_o        (done)
    );

    task automatic load_program();
        int                      fd;
        int                      code;
        logic [7:0]              tag;
        logic [rv_pkg::XLEN-1:0] word;
        logic [8*160-1:0]        rest;
        // Unused words hold an unknown opcode tagged with their index
        for (int i = 0; i < 64; i++) begin
            imem[i] = 32'(i) << 7;
        end
        fd = $fopen("rv_core_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open the golden file");
            tb_errors++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", tag);
            if (code != 1) begin
                break;
            end
            if (tag == "P") begin
                code = $fscanf(fd, "%h", word);
                imem[prog_words] = word;
                prog_words++;
            end else begin
                code = $fgets(rest, fd);
            end
        end
        $fclose(fd);
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        tb_errors  = 0;
        prog_words = 0;
        load_program();
        repeat (8) @(posedge clk);
        #2 rst_n = 1'b1;
        if (prog_words == 0 || expected == 0) begin
            $display("golden file holds no program or no expected retirements");
            tb_errors++;
        end
        seen = 0;
        while (tb_errors == 0 && seen < expected) begin
            waited = 0;
            while (retired == seen && waited < RETIRE_TIMEOUT) begin
                @(posedge clk);
                waited++;
            end
            if (retired == seen) begin
                $display("timeout waiting for retirement %0d", seen);
                tb_errors++;
            end else begin
                seen = retired;
            end
        end
        @(posedge clk);
        $display("Summary: %0d checker errors, %0d testbench errors", chk_errors, tb_errors);
        if (chk_errors == 0 && tb_errors == 0 && done) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- rv_core_golden.txt
# P word : program word, stored from address 0 up
# R pc rd data : expected retirement in order, C n : expected redirect cycles
P 00500093
P FFD00113
P 002081B3
P 40208233
P 0041F2B3
P 0041E333
P 001343B3
P 00309433
P 003154B3
P 40315533
P 001125B3
P 00113633
P 123456B7
P 6786E713
P 0F077793
P FFF7C813
P FFE12893
P 0040B913
P 00409993
P 01C85A13
P 40485A93
P 00708013
P 00108463
P 00100B13
P 00109463
P 00114463
P 00200B13
P 00115463
P 0020E463
P 00300B13
P 0020F463
P 00400C13
P 00000B93
P 001B8B93
P FF8BCEE3
P 00800CEF
P 00400B13
P 017C8D33
P 0000006F
R 00000000 01 00000005
R 00000004 02 FFFFFFFD
R 00000008 03 00000002
R 0000000C 04 00000008
R 00000010 05 00000000
R 00000014 06 0000000A
R 00000018 07 0000000F
R 0000001C 08 00000014
R 00000020 09 3FFFFFFF
R 00000024 0A FFFFFFFF
R 00000028 0B 00000001
R 0000002C 0C 00000000
R 00000030 0D 12345000
R 00000034 0E 12345678
R 00000038 0F 00000070
R 0000003C 10 FFFFFF8F
R 00000040 11 00000001
R 00000044 12 00000000
R 00000048 13 00000050
R 0000004C 14 0000000F
R 00000050 15 FFFFFFF8
R 00000054 00 00000000
R 00000058 00 00000000
R 00000060 00 00000000
R 00000064 00 00000000
R 0000006C 00 00000000
R 00000070 00 00000000
R 00000078 00 00000000
R 0000007C 18 00000004
R 00000080 17 00000000
R 00000084 17 00000001
R 00000088 00 00000000
R 00000084 17 00000002
R 00000088 00 00000000
R 00000084 17 00000003
R 00000088 00 00000000
R 00000084 17 00000004
R 00000088 00 00000000
R 0000008C 19 00000090
R 00000094 1A 00000094
R 00000098 00 00000000
C 7

//--- rv_core.f
rv_pkg.sv
rv_pipe_if.sv
branch_predictor.sv
fetch_stage.sv
regfile.sv
decode_stage.sv
alu.sv
execute_stage.sv
rv_core.sv
rv_checker.sv
tb_rv_core.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - rv_pkg.sv
  - rv_pipe_if.sv
  - branch_predictor.sv
  - fetch_stage.sv
  - regfile.sv
  - decode_stage.sv
  - alu.sv
  - execute_stage.sv
  - rv_core.sv
  - target: test
    files:
      - rv_checker.sv
      - tb_rv_core.sv
